//--- sd_cmd_unit.sv
`timescale 1ns/10ps
`default_nettype none

module sd_cmd_unit import sd_pkg::*; #(
    parameter int RESP_TIMEOUT = 100
) (
    input  wire         clk,
    input  wire         reset_n,
    input  wire         op_start,
    input  wire link_op_e op_kind,
    input  wire sd_cmd_e  cmd,
    input  wire  [31:0] cmd_arg,
    input  wire         xfer_done,
    input  wire   [7:0] rx_byte,
    output logic        op_done,
    output logic  [7:0] op_resp,
    output logic        op_timeout,
    output logic        xfer_start,
    output logic  [7:0] tx_byte
);

    localparam int CNT_W = $clog2(RESP_TIMEOUT + 6);

    typedef enum logic [1:0] {S_IDLE, S_SEND, S_POLL, S_XFER} unit_state_e;

    unit_state_e      state;
    logic [CNT_W-1:0] byte_cnt;  // Command byte index, then poll count
    logic             next_go;   // Launch following byte

    // First byte goes out in the op_start cycle
    assign xfer_start = (state == S_IDLE && op_start) || next_go;

    always_comb begin
        tx_byte = FILL_BYTE;
        if (state == S_IDLE && op_kind == OP_CMD) begin
            tx_byte = cmd;
        end else if (state == S_SEND) begin
            case (byte_cnt)
                CNT_W'(1): tx_byte = cmd_arg[31:24];
                CNT_W'(2): tx_byte = cmd_arg[23:16];
                CNT_W'(3): tx_byte = cmd_arg[15:8];
                CNT_W'(4): tx_byte = cmd_arg[7:0];
                default:   tx_byte = cmd_crc(cmd);
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= S_IDLE;
            byte_cnt   <= '0;
            next_go    <= 1'b0;
            op_done    <= 1'b0;
            op_timeout <= 1'b0;
        end else begin
            next_go <= 1'b0;
            op_done <= 1'b0;
            case (state)
                S_IDLE: if (op_start) begin
                    byte_cnt <= '0;
                    state    <= (op_kind == OP_CMD) ? S_SEND : S_XFER;
                end
                S_SEND: if (xfer_done) begin
                    next_go <= 1'b1;
                    if (byte_cnt == CNT_W'(5)) begin  // CRC byte out
                        byte_cnt <= '0;
                        state    <= S_POLL;
                    end else begin
                        byte_cnt <= byte_cnt + CNT_W'(1);
                    end
                end
                S_POLL: if (xfer_done) begin
                    if (!rx_byte[7] || byte_cnt == CNT_W'(RESP_TIMEOUT - 1)) begin
                        op_done    <= 1'b1;
                        op_timeout <= rx_byte[7];  // Still no R1
                        state      <= S_IDLE;
                    end else begin
                        byte_cnt <= byte_cnt + CNT_W'(1);
                        next_go  <= 1'b1;
                    end
                end
                default: if (xfer_done) begin
                    op_done    <= 1'b1;
                    op_timeout <= 1'b0;
                    state      <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (xfer_done) op_resp <= rx_byte;
    end

endmodule

`default_nettype wire

//--- sd_controller.f
sd_pkg.sv
spi_byte_engine.sv
sd_cmd_unit.sv
sd_sequencer.sv
sd_controller.sv
tb_sd_card.sv
tb_sd_controller.sv

//--- sd_controller.sv
`timescale 1ns/10ps
`default_nettype none

module sd_controller import sd_pkg::*; #(
    parameter int CLK_DIV       = 2,    // System clocks per half SPI clock
    parameter int RESP_TIMEOUT  = 100,  // Filler bytes before R1 gives up
    parameter int TOKEN_TIMEOUT = 100,
    parameter int INIT_RETRIES  = 100
) (
    input  wire        clk,
    input  wire        reset_n,
    input  wire        start_read,
    input  wire [31:0] read_addr,
    input  wire        spi_miso,
    output wire        spi_cs,
    output wire        spi_sclk,
    output wire        spi_mosi,
    output wire        card_ready,
    output wire        busy,
    output wire  [7:0] data_out,
    output wire        data_valid,
    output wire        read_done,
    output wire        read_error
);

    // Sequencer to command unit
    logic        op_start;
    link_op_e    op_kind;
    sd_cmd_e     cmd;
    logic [31:0] cmd_arg;
    logic        op_done;
    logic  [7:0] op_resp;
    logic        op_timeout;

    // Command unit to byte engine
    logic        xfer_start;
    logic  [7:0] tx_byte;
    logic        xfer_done;
    logic  [7:0] rx_byte;

    spi_byte_engine #(
        .CLK_DIV(CLK_DIV)
    ) spi_byte_engine_i (
        .clk(clk), .reset_n(reset_n),
        .xfer_start(xfer_start), .tx_byte(tx_byte), .miso(spi_miso),
        .xfer_done(xfer_done), .rx_byte(rx_byte), .sclk(spi_sclk), .mosi(spi_mosi)
    );

    sd_cmd_unit #(
        .RESP_TIMEOUT(RESP_TIMEOUT)
    ) sd_cmd_unit_i (
        .clk(clk), .reset_n(reset_n),
        .op_start(op_start), .op_kind(op_kind), .cmd(cmd), .cmd_arg(cmd_arg),
        .xfer_done(xfer_done), .rx_byte(rx_byte),
        .op_done(op_done), .op_resp(op_resp), .op_timeout(op_timeout),
        .xfer_start(xfer_start), .tx_byte(tx_byte)
    );

    sd_sequencer #(
        .TOKEN_TIMEOUT(TOKEN_TIMEOUT),
        .INIT_RETRIES(INIT_RETRIES)
    ) sd_sequencer_i (
        .clk(clk), .reset_n(reset_n),
        .start_read(start_read), .read_addr(read_addr),
        .op_done(op_done), .op_resp(op_resp), .op_timeout(op_timeout),
        .op_start(op_start), .op_kind(op_kind), .cmd(cmd), .cmd_arg(cmd_arg),
        .cs(spi_cs), .card_ready(card_ready), .busy(busy),
        .data_out(data_out), .data_valid(data_valid),
        .read_done(read_done), .read_error(read_error)
    );

endmodule

`default_nettype wire

//--- sd_pkg.sv
`default_nettype none

package sd_pkg;

    // Command bytes with start and transmission bits
    typedef enum logic [7:0] {
        CMD0   = 8'h40,  // GO_IDLE_STATE
        CMD8   = 8'h48,  // SEND_IF_COND
        CMD17  = 8'h51,  // READ_SINGLE_BLOCK
        CMD55  = 8'h77,  // APP_CMD
        ACMD41 = 8'h69   // SD_SEND_OP_COND
    } sd_cmd_e;

    typedef enum logic {
        OP_CMD  = 1'b0,  // Full command plus R1 poll
        OP_XFER = 1'b1   // Single filler byte
    } link_op_e;

    localparam logic [7:0]  FILL_BYTE   = 8'hFF;
    localparam logic [7:0]  DATA_TOKEN  = 8'hFE;
    localparam logic [7:0]  R1_IDLE     = 8'h01;
    localparam logic [7:0]  R1_READY    = 8'h00;
    localparam logic [31:0] CMD8_ARG    = 32'h0000_01AA;  // 2.7-3.6 V, check pattern AA
    localparam logic [31:0] ACMD41_ARG  = 32'h4000_0000;  // HCS bit
    localparam int          BLOCK_BYTES = 512;

    // Precomputed CRC7 plus end bit, only valid for the fixed arguments
    function automatic logic [7:0] cmd_crc(input sd_cmd_e c);
        case (c)
            CMD0:    return 8'h95;
            CMD8:    return 8'h87;
            CMD55:   return 8'h65;
            ACMD41:  return 8'h77;
            default: return 8'hFF;  // CRC off in SPI mode
        endcase
    endfunction

endpackage

`default_nettype wire

//--- sd_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module sd_sequencer import sd_pkg::*; #(
    parameter int TOKEN_TIMEOUT = 100,
    parameter int INIT_RETRIES  = 100
) (
    input  wire         clk,
    input  wire         reset_n,
    input  wire         start_read,
    input  wire  [31:0] read_addr,
    input  wire         op_done,
    input  wire   [7:0] op_resp,
    input  wire         op_timeout,
    output logic        op_start,
    output link_op_e    op_kind,
    output sd_cmd_e     cmd,
    output logic [31:0] cmd_arg,
    output logic        cs,
    output logic        card_ready,
    output logic        busy,
    output logic  [7:0] data_out,
    output logic        data_valid,
    output logic        read_done,
    output logic        read_error
);

    localparam int CNT_A   = (INIT_RETRIES > TOKEN_TIMEOUT) ? INIT_RETRIES : TOKEN_TIMEOUT;
    localparam int CNT_MAX = (CNT_A > BLOCK_BYTES) ? CNT_A : BLOCK_BYTES;
    localparam int CNT_W   = $clog2(CNT_MAX);

    typedef enum logic [3:0] {
        ST_IDLE_CLK, ST_CMD0, ST_CMD8, ST_R7, ST_CMD55, ST_ACMD41,
        ST_READY, ST_CMD17, ST_TOKEN, ST_DATA, ST_CRC, ST_BUSY
    } seq_state_e;

    seq_state_e       state;
    logic [CNT_W-1:0] cnt;      // Bytes, retries or timeout count
    logic             op_wait;  // Operation in flight
    logic [31:0]      addr_q;
    logic             r1_idle;

    assign r1_idle = !op_timeout && op_resp == R1_IDLE;

    // Request fields follow the state, so they hold until op_done
    always_comb begin
        op_kind = OP_CMD;
        cmd     = CMD0;
        cmd_arg = '0;
        case (state)
            ST_CMD8: begin
                cmd     = CMD8;
                cmd_arg = CMD8_ARG;
            end
            ST_CMD55: cmd = CMD55;
            ST_ACMD41: begin
                cmd     = ACMD41;
                cmd_arg = ACMD41_ARG;
            end
            ST_CMD17: begin
                cmd     = CMD17;
                cmd_arg = addr_q;
            end
            ST_CMD0:  cmd = CMD0;
            default:  op_kind = OP_XFER;  // Filler byte states
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= ST_IDLE_CLK;
            cnt        <= '0;
            op_wait    <= 1'b0;
            op_start   <= 1'b0;
            cs         <= 1'b1;
            card_ready <= 1'b0;
            busy       <= 1'b0;
            data_valid <= 1'b0;
            read_done  <= 1'b0;
            read_error <= 1'b0;
        end else begin
            op_start   <= 1'b0;
            data_valid <= 1'b0;
            read_done  <= 1'b0;
            if (state != ST_READY && !op_wait) begin
                op_start <= 1'b1;
                op_wait  <= 1'b1;
                busy     <= 1'b1;
                if (state == ST_IDLE_CLK)
                    cs <= 1'b1;  // Deselected for the idle clocks
            end
            if (state == ST_READY && start_read) begin
                state <= ST_CMD17;
                busy  <= 1'b1;
                cs    <= 1'b0;
            end
            if (op_done) begin
                op_wait <= 1'b0;
                cnt     <= cnt + CNT_W'(1);
                case (state)
                    ST_IDLE_CLK: if (cnt == CNT_W'(9)) begin  // 80 clocks done
                        cnt   <= '0;
                        cs    <= 1'b0;
                        state <= ST_CMD0;
                    end
                    ST_CMD0:  state <= r1_idle ? ST_CMD8 : ST_IDLE_CLK;
                    ST_CMD8:  state <= r1_idle ? ST_R7 : ST_IDLE_CLK;
                    ST_R7: if (cnt == CNT_W'(3)) begin
                        cnt   <= '0;  // Retry count starts here
                        state <= (op_resp == CMD8_ARG[7:0]) ? ST_CMD55 : ST_IDLE_CLK;
                    end
                    ST_CMD55: begin
                        cnt   <= r1_idle ? cnt : '0;
                        state <= r1_idle ? ST_ACMD41 : ST_IDLE_CLK;
                    end
                    ST_ACMD41: begin
                        if (!op_timeout && op_resp == R1_READY) begin
                            card_ready <= 1'b1;
                            busy       <= 1'b0;
                            cs         <= 1'b1;
                            state      <= ST_READY;
                        end else if (r1_idle && cnt != CNT_W'(INIT_RETRIES - 1)) begin
                            state <= ST_CMD55;
                        end else begin
                            cnt   <= '0;
                            state <= ST_IDLE_CLK;
                        end
                    end
                    ST_CMD17: begin
                        cnt <= '0;
                        if (op_timeout || op_resp != R1_READY) begin
                            read_error <= 1'b1;
                            read_done  <= 1'b1;
                            busy       <= 1'b0;
                            cs         <= 1'b1;
                            state      <= ST_READY;
                        end else begin
                            read_error <= 1'b0;
                            state      <= ST_TOKEN;
                        end
                    end
                    ST_TOKEN: if (op_resp == DATA_TOKEN) begin
                        cnt   <= '0;
                        state <= ST_DATA;
                    end else if (cnt == CNT_W'(TOKEN_TIMEOUT - 1)) begin
                        read_error <= 1'b1;
                        read_done  <= 1'b1;
                        busy       <= 1'b0;
                        cs         <= 1'b1;
                        state      <= ST_READY;
                    end
                    ST_DATA: begin
                        data_valid <= 1'b1;
                        if (cnt == CNT_W'(BLOCK_BYTES - 1)) begin
                            cnt   <= '0;
                            state <= ST_CRC;
                        end
                    end
                    ST_CRC: if (cnt == CNT_W'(1)) begin  // CRC16 dropped
                        cnt   <= '0;
                        state <= ST_BUSY;
                    end
                    ST_BUSY: if (op_resp == FILL_BYTE || cnt == CNT_W'(TOKEN_TIMEOUT - 1)) begin
                        read_error <= (op_resp != FILL_BYTE);  // Card held busy too long
                        read_done  <= 1'b1;
                        busy       <= 1'b0;
                        cs         <= 1'b1;
                        state      <= ST_READY;
                    end
                    default: state <= state;
                endcase
                if (state inside {ST_CMD0, ST_CMD8})
                    cnt <= '0;  // R7 bytes and idle clocks count from zero
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_READY && start_read) addr_q <= read_addr;
        if (op_done && state == ST_DATA) data_out <= op_resp;
    end

endmodule

`default_nettype wire

//--- spi_byte_engine.sv
`timescale 1ns/10ps
`default_nettype none

module spi_byte_engine #(
    parameter int CLK_DIV = 2
) (
    input  wire        clk,
    input  wire        reset_n,
    input  wire        xfer_start,
    input  wire  [7:0] tx_byte,
    input  wire        miso,
    output logic       xfer_done,
    output logic [7:0] rx_byte,
    output logic       sclk,
    output logic       mosi
);

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic             active;
    logic [DIV_W-1:0] div_cnt;
    logic [3:0]       bit_cnt;   // Rising edges seen
    logic [7:0]       tx_shift;
    logic [7:0]       rx_shift;
    logic             tick;      // Half period elapsed

    assign tick      = active && (div_cnt == DIV_W'(CLK_DIV - 1));
    assign xfer_done = tick && sclk && (bit_cnt == 4'd8);  // Last falling edge
    assign rx_byte   = rx_shift;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            active  <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
            sclk    <= 1'b0;
            mosi    <= 1'b1;
        end else if (!active) begin
            if (xfer_start) begin
                active  <= 1'b1;
                div_cnt <= '0;
                bit_cnt <= '0;
                mosi    <= tx_byte[7];  // MSB ahead of first rising edge
            end
        end else if (tick) begin
            div_cnt <= '0;
            sclk    <= ~sclk;
            if (!sclk) begin
                bit_cnt <= bit_cnt + 4'd1;
            end else if (bit_cnt == 4'd8) begin
                active <= 1'b0;
                mosi   <= 1'b1;  // Idle high between bytes
            end else begin
                mosi <= tx_shift[7];
            end
        end else begin
            div_cnt <= div_cnt + DIV_W'(1);
        end
    end

    // Shift registers
    always_ff @(posedge clk) begin
        if (!active && xfer_start)
            tx_shift <= {tx_byte[6:0], 1'b1};
        else if (tick && sclk && bit_cnt != 4'd8)
            tx_shift <= {tx_shift[6:0], 1'b1};
        if (tick && !sclk)
            rx_shift <= {rx_shift[6:0], miso};  // Sample on rising edge
    end

endmodule

`default_nettype wire

//--- tb_sd_card.sv
`timescale 1ns/10ps
`default_nettype none

module tb_sd_card import sd_pkg::*; (
    input  wire         cs,
    input  wire         sclk,
    input  wire         mosi,
    output wire         miso,
    input  wire         no_token,     // Never send the data token
    input  wire   [2:0] acmd41_idle,  // ACMD41 answers before ready
    input  wire   [2:0] token_delay,  // Filler bytes ahead of the token
    input  wire   [3:0] busy_len,     // Busy bytes after the CRC
    output int          cmd_cnt,
    output int          init_edges,   // sclk edges with cs high before CMD0
    output logic  [7:0] last_cmd,
    output logic [31:0] last_arg
);

    logic [7:0] rx_sr;
    logic [7:0] tx_sr;
    logic [7:0] cmd_buf [0:5];
    logic [7:0] out_q [$];  // Bytes queued for the host
    int         rx_bits;
    int         tx_bits;
    int         cmd_idx;
    int         acmd41_cnt;

    assign miso = tx_sr[7];

    initial begin
        tx_sr      = FILL_BYTE;
        rx_sr      = 8'h00;
        rx_bits    = 0;
        tx_bits    = 0;
        cmd_idx    = 0;
        acmd41_cnt = 0;
        cmd_cnt    = 0;
        init_edges = 0;
        last_cmd   = 8'h00;
        last_arg   = 32'h0;
    end

    // Block content mixed from the sector address
    function automatic logic [7:0] block_byte(input logic [31:0] addr, input int idx);
        logic [31:0] h;
        h = (addr ^ (32'(idx) * 32'h9E37_79B1)) * 32'h85EB_CA6B;
        return h[23:16] ^ h[7:0];
    endfunction

    task automatic run_command();
        logic [7:0]  c;
        logic [31:0] a;
        int          i;
        c = cmd_buf[0];
        a = {cmd_buf[1], cmd_buf[2], cmd_buf[3], cmd_buf[4]};
        last_cmd = c;
        last_arg = a;
        cmd_cnt++;
        out_q.delete();
        out_q.push_back(FILL_BYTE);  // R1 comes one byte late
        case (c)
            CMD0, CMD55: out_q.push_back(R1_IDLE);
            CMD8: begin
                out_q.push_back(R1_IDLE);
                out_q.push_back(8'h00);
                out_q.push_back(8'h00);
                out_q.push_back({4'h0, a[11:8]});  // Voltage echo
                out_q.push_back(a[7:0]);
            end
            ACMD41: begin
                acmd41_cnt++;
                out_q.push_back((acmd41_cnt > acmd41_idle) ? R1_READY : R1_IDLE);
            end
            CMD17: begin
                out_q.push_back(R1_READY);
                if (!no_token) begin
                    repeat (token_delay) out_q.push_back(FILL_BYTE);
                    out_q.push_back(DATA_TOKEN);
                    for (i = 0; i < BLOCK_BYTES; i++)
                        out_q.push_back(block_byte(a, i));
                    out_q.push_back(8'hC3);  // CRC16, never checked
                    out_q.push_back(8'h3C);
                    repeat (busy_len) out_q.push_back(8'h00);
                end
            end
            default: out_q.push_back(8'h05);  // Illegal command
        endcase
    endtask

    always @(posedge sclk) begin
        if (cs) begin
            if (cmd_cnt == 0) init_edges++;
            rx_bits = 0;
        end else begin
            rx_sr = {rx_sr[6:0], mosi};
            rx_bits++;
            if (rx_bits == 8) begin
                rx_bits = 0;
                if (cmd_idx > 0 || rx_sr[7:6] == 2'b01) begin  // Start of a command
                    cmd_buf[cmd_idx] = rx_sr;
                    cmd_idx++;
                end
                if (cmd_idx == 6) begin
                    cmd_idx = 0;
                    run_command();
                end
            end
        end
    end

    // Next bit goes out after each falling edge
    always @(negedge sclk) begin
        if (!cs) begin
            tx_bits++;
            if (tx_bits == 8) begin
                tx_bits = 0;
                if (out_q.size() > 0)
                    tx_sr = out_q.pop_front();
                else
                    tx_sr = FILL_BYTE;
            end else begin
                tx_sr = {tx_sr[6:0], 1'b1};
            end
        end
    end

    always @(posedge cs) begin
        tx_bits = 0;
        rx_bits = 0;
        cmd_idx = 0;
        tx_sr   = FILL_BYTE;
        out_q.delete();
    end

endmodule

`default_nettype wire

//--- tb_sd_controller.sv
`timescale 1ns/10ps
`default_nettype none

module tb_sd_controller import sd_pkg::*; ();

    localparam int     CLK_DIV     = 2;
    localparam int     NUM_READS   = 13;  // Random, poked, timeout and recovery reads
    localparam longint WATCHDOG_NS = longint'(NUM_READS + 2) * 600 * 16 * CLK_DIV * 40;

    logic        clk;
    logic        reset_n;
    logic        start_read;
    logic [31:0] read_addr;
    wire         spi_miso;
    wire         spi_cs;
    wire         spi_sclk;
    wire         spi_mosi;
    wire         card_ready;
    wire         busy;
    wire  [7:0]  data_out;
    wire         data_valid;
    wire         read_done;
    wire         read_error;

    // Card model controls and log outputs
    logic        no_token;
    logic [2:0]  acmd41_idle;
    logic [2:0]  token_delay;
    logic [3:0]  busy_len;
    wire  [31:0] cmd_cnt;
    wire  [31:0] init_edges;
    wire  [7:0]  last_cmd;
    wire  [31:0] last_arg;

    logic [39:0] cmd_log [$];   // {command, argument}
    logic [7:0]  rx_bytes [$];
    int          errors = 0;
    int          tests = 0;
    int          failed_tests = 0;

    sd_controller #(
        .CLK_DIV(CLK_DIV)
    ) sd_controller_i (
        .clk(clk), .reset_n(reset_n), .start_read(start_read), .read_addr(read_addr),
        .spi_miso(spi_miso), .spi_cs(spi_cs), .spi_sclk(spi_sclk), .spi_mosi(spi_mosi),
        .card_ready(card_ready), .busy(busy), .data_out(data_out),
        .data_valid(data_valid), .read_done(read_done), .read_error(read_error)
    );

    tb_sd_card card_i (
        .cs(spi_cs), .sclk(spi_sclk), .mosi(spi_mosi), .miso(spi_miso),
        .no_token(no_token), .acmd41_idle(acmd41_idle), .token_delay(token_delay),
        .busy_len(busy_len), .cmd_cnt(cmd_cnt), .init_edges(init_edges),
        .last_cmd(last_cmd), .last_arg(last_arg)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(negedge clk) begin
        if (cmd_cnt != cmd_log.size()) cmd_log.push_back({last_cmd, last_arg});
        if (data_valid) rx_bytes.push_back(data_out);
    end

    task automatic check(input string name, input logic [39:0] expected,
                         input logic [39:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("Test %s: ok", name);
        end else begin
            failed_tests++;
            $display("Test %s: %0d failed checks", name, errors - errors_before);
        end
    endtask

    // Expected start-up command k: CMD0, CMD8, then CMD55/ACMD41 pairs
    function automatic logic [39:0] startup_cmd(input int k);
        if (k == 0) return {CMD0, 32'h0};
        if (k == 1) return {CMD8, CMD8_ARG};
        if (k % 2 == 0) return {CMD55, 32'h0};
        return {ACMD41, ACMD41_ARG};
    endfunction

    task automatic run_read(input string name, input logic [31:0] addr,
                            input bit expect_err, input bit poke);
        int   errors_before;
        int   log_before;
        int   data_errors;
        logic prev_busy;
        errors_before = errors;
        log_before    = cmd_log.size();
        @(negedge clk);
        token_delay = 3'(1 + $urandom % 5);
        busy_len    = 4'($urandom % 9);
        rx_bytes.delete();
        read_addr   = addr;
        start_read  = 1'b1;
        @(negedge clk);
        start_read  = 1'b0;
        check({name, " busy"}, 1, busy);
        if (poke) begin
            repeat (3) begin  // Requests while busy must be dropped
                repeat (300) @(negedge clk);
                read_addr  = ~addr;
                start_read = 1'b1;
                @(negedge clk);
                start_read = 1'b0;
            end
        end
        prev_busy = busy;
        @(negedge clk);
        while (!read_done) begin
            prev_busy = busy;
            @(negedge clk);
        end
        check({name, " read_error"}, expect_err, read_error);
        check({name, " busy fall"}, 2'b10, {prev_busy, busy});
        @(negedge clk);
        check({name, " single done"}, 0, read_done);
        check({name, " card_ready"}, 1, card_ready);
        check({name, " CMD17 count"}, log_before + 1, cmd_log.size());
        if (cmd_log.size() > log_before)
            check({name, " CMD17"}, {CMD17, addr}, cmd_log[log_before]);
        check({name, " strobes"}, expect_err ? 0 : BLOCK_BYTES, rx_bytes.size());
        data_errors = errors;
        for (int i = 0; i < rx_bytes.size() && errors == data_errors; i++)
            check({name, " data"}, card_i.block_byte(addr, i), rx_bytes[i]);
        report_test(name, errors_before);
    endtask

    initial begin
        int errors_before;
        int seed_val;
        seed_val    = $urandom(32'h9b48_48ff);
        reset_n     = 1'b0;
        start_read  = 1'b0;
        read_addr   = 32'h0;
        no_token    = 1'b0;
        acmd41_idle = 3'(1 + $urandom % 4);
        token_delay = 3'd1;
        busy_len    = 4'd0;

        repeat (8) @(negedge clk);
        reset_n = 1'b1;
        errors_before = errors;
        check("reset cs", 1, spi_cs);
        check("reset sclk", 0, spi_sclk);
        check("reset busy", 0, busy);
        check("reset card_ready", 0, card_ready);
        check("reset read_done", 0, read_done);
        check("reset data_valid", 0, data_valid);
        check("reset read_error", 0, read_error);
        report_test("reset", errors_before);

        errors_before = errors;
        wait (card_ready === 1'b1);
        @(negedge clk);
        check("startup busy", 0, busy);
        check("startup idle edges", 1, init_edges >= 32'd74);
        check("startup command count", 2 + 2 * (acmd41_idle + 1), cmd_log.size());
        for (int k = 0; k < cmd_log.size(); k++)
            check("startup command", startup_cmd(k), cmd_log[k]);
        report_test("startup", errors_before);

        for (int n = 0; n < 10; n++)
            run_read($sformatf("read %0d", n), $urandom, 1'b0, 1'b0);
        run_read("ignored requests", $urandom, 1'b0, 1'b1);
        no_token = 1'b1;
        run_read("token timeout", $urandom, 1'b1, 1'b0);
        no_token = 1'b0;
        run_read("read after timeout", $urandom, 1'b0, 1'b0);

        $display("Tests: %0d run, %0d failed, %0d failed checks", tests, failed_tests, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the reads did not finish within %0d ns", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire
